// ==== design/cpu_pkg.sv ====
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// CPU package
// Bus, instruction and frame types for the accumulator CPU
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`default_nettype none

package cpu_pkg;

  typedef logic [31:0] word_t;  // Data and address word
  typedef logic [7:0]  byte_t;  // One pin byte

  // Top nibble of an instruction word
  typedef enum logic [3:0] {
    op_halt  = 4'd0,
    op_load  = 4'd1,
    op_store = 4'd2,
    op_add   = 4'd3,
    op_sub   = 4'd4,
    op_and   = 4'd5,
    op_xor   = 4'd6,
    op_ldi   = 4'd7,
    op_jmp   = 4'd8,
    op_jz    = 4'd9
  } opcode_t;

  localparam int operand_bits = 28;  // Address or immediate field, zero-extended

  // One memory transaction, held by the core for a whole frame
  typedef struct packed {
    logic  write;  // 1 = store, 0 = read
    word_t addr;   // Word address
    word_t wdata;  // Store data, ignored on reads
  } bus_req_t;

  typedef enum logic [1:0] {
    alu_add = 2'd0,
    alu_sub = 2'd1,
    alu_and = 2'd2,
    alu_xor = 2'd3
  } alu_op_t;

  // Frame layout: step, 4 address bytes, flag byte, 4 read bytes
  localparam int frame_len = 10;

  typedef logic [3:0] phase_t;  // 0 .. frame_len-1

endpackage

`default_nettype wire

// ==== design/cpu_alu.sv ====
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// CPU ALU
// Accumulator arithmetic and zero flag
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`default_nettype none

module cpu_alu (
  input  wire cpu_pkg::word_t   a,       // Accumulator
  input  wire cpu_pkg::word_t   b,       // Memory operand
  input  wire cpu_pkg::alu_op_t op,
  output cpu_pkg::word_t        result,
  output logic                  zero
);

  // All operations wrap at 32 bits
  always_comb begin
    result = a;
    case (op)
      cpu_pkg::alu_add: begin
        result = a + b;
      end
      cpu_pkg::alu_sub: begin
        result = a - b;
      end
      cpu_pkg::alu_and: begin
        result = a & b;
      end
      cpu_pkg::alu_xor: begin
        result = a ^ b;
      end
      default: begin
        result = a;
      end
    endcase
  end

  // Jz looks at the accumulator itself, not the result
  assign zero = (a == '0);

endmodule

`default_nettype wire

// ==== design/bus_frame_sequencer.sv ====
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Bus frame sequencer
// Cuts each bus request into a ten-cycle byte frame
// and gathers the read word from the pins
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`default_nettype none

module bus_frame_sequencer (
  input  wire                   clk,
  input  wire                   reset,
  input  wire cpu_pkg::bus_req_t req,
  output logic                  step,
  output cpu_pkg::word_t        rdata,
  input  wire cpu_pkg::byte_t   uio_in,
  output cpu_pkg::byte_t        uo_out,
  output cpu_pkg::byte_t        uio_out,
  output cpu_pkg::byte_t        uio_oe
);

  cpu_pkg::phase_t phase;
  logic            last_phase;

  assign last_phase = (phase == cpu_pkg::phase_t'(cpu_pkg::frame_len - 1));

  // Phase counter, one full frame per wrap
  always_ff @(posedge clk) begin
    if (reset) begin
      phase <= '0;
    end else if (last_phase) begin
      phase <= '0;
    end else begin
      phase <= phase + 4'd1;
    end
  end

  assign step = (phase == '0);  // Core advances once per frame

  // Registered pin drivers, each value shows one cycle after its phase
  always_ff @(posedge clk) begin
    if (reset) begin
      uo_out  <= '0;
      uio_out <= '0;
      uio_oe  <= '0;
    end else begin
      uio_oe <= {8{req.write}};  // Drive data pins only for stores
      case (phase)
        4'd1: begin
          uo_out  <= req.addr[7:0];
          uio_out <= req.wdata[7:0];
        end
        4'd2: begin
          uo_out  <= req.addr[15:8];
          uio_out <= req.wdata[15:8];
        end
        4'd3: begin
          uo_out  <= req.addr[23:16];
          uio_out <= req.wdata[23:16];
        end
        4'd4: begin
          uo_out  <= req.addr[31:24];
          uio_out <= req.wdata[31:24];
        end
        4'd5: begin
          uo_out  <= {7'b0, req.write};  // Flag byte
          uio_out <= '0;
        end
        default: begin
          uo_out  <= '0;
          uio_out <= '0;
        end
      endcase
    end
  end

  // Read word capture, low byte first
  always_ff @(posedge clk) begin
    case (phase)
      4'd6:    rdata[7:0]   <= uio_in;
      4'd7:    rdata[15:8]  <= uio_in;
      4'd8:    rdata[23:16] <= uio_in;
      4'd9:    rdata[31:24] <= uio_in;
      default: rdata        <= rdata;
    endcase
  end

endmodule

`default_nettype wire

// ==== design/cpu_core.sv ====
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// CPU core
// Accumulator machine, one bus request per frame step
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`default_nettype none

module cpu_core (
  input  wire                    clk,
  input  wire                    reset,
  input  wire                    step,
  input  wire cpu_pkg::word_t    rdata,
  output cpu_pkg::bus_req_t      req,
  output cpu_pkg::alu_op_t       alu_op,
  output cpu_pkg::word_t         acc,
  input  wire cpu_pkg::word_t    alu_result,
  input  wire                    alu_zero
);

  typedef enum logic [1:0] {
    st_start,  // First step after reset, nothing fetched yet
    st_fetch,  // Last request was an instruction fetch
    st_exec,   // Last request was an operand access
    st_halt
  } state_t;

  state_t            state;
  cpu_pkg::word_t    pc;
  cpu_pkg::opcode_t  opcode_q;  // Opcode waiting for its operand
  cpu_pkg::opcode_t  fetch_op;
  cpu_pkg::word_t    operand;
  cpu_pkg::word_t    pc_next;

  // Decode of the word that just arrived as an instruction
  assign fetch_op = cpu_pkg::opcode_t'(rdata[31:28]);
  assign operand  = {{(32 - cpu_pkg::operand_bits){1'b0}},
                     rdata[cpu_pkg::operand_bits-1:0]};
  assign pc_next  = pc + 32'd1;

  function automatic cpu_pkg::bus_req_t read_req(input cpu_pkg::word_t addr);
    cpu_pkg::bus_req_t r;
    r.write = 1'b0;
    r.addr  = addr;
    r.wdata = '0;
    return r;
  endfunction

  // ALU operation for the pending arithmetic opcode
  always_comb begin
    case (opcode_q)
      cpu_pkg::op_sub: alu_op = cpu_pkg::alu_sub;
      cpu_pkg::op_and: alu_op = cpu_pkg::alu_and;
      cpu_pkg::op_xor: alu_op = cpu_pkg::alu_xor;
      default:         alu_op = cpu_pkg::alu_add;
    endcase
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      state    <= st_start;
      pc       <= '0;
      acc      <= '0;
      opcode_q <= cpu_pkg::op_halt;
      req      <= '0;
    end else if (step) begin
      case (state)
        st_start: begin
          req   <= read_req(pc);  // Fetch of instruction 0
          state <= st_fetch;
        end
        st_fetch: begin
          opcode_q <= fetch_op;
          case (fetch_op)
            cpu_pkg::op_load, cpu_pkg::op_add, cpu_pkg::op_sub,
            cpu_pkg::op_and, cpu_pkg::op_xor: begin
              pc    <= pc_next;
              req   <= read_req(operand);
              state <= st_exec;
            end
            cpu_pkg::op_store: begin
              pc        <= pc_next;
              req.write <= 1'b1;
              req.addr  <= operand;
              req.wdata <= acc;
              state     <= st_exec;
            end
            cpu_pkg::op_ldi: begin
              acc <= operand;
              pc  <= pc_next;
              req <= read_req(pc_next);
            end
            cpu_pkg::op_jmp: begin
              pc  <= operand;
              req <= read_req(operand);
            end
            cpu_pkg::op_jz: begin
              // Zero flag follows the accumulator
              pc  <= alu_zero ? operand : pc_next;
              req <= read_req(alu_zero ? operand : pc_next);
            end
            default: begin
              req   <= read_req(pc);  // Halt or unknown opcode
              state <= st_halt;
            end
          endcase
        end
        st_exec: begin
          case (opcode_q)
            cpu_pkg::op_load:  acc <= rdata;
            cpu_pkg::op_store: acc <= acc;
            default:           acc <= alu_result;
          endcase
          req   <= read_req(pc);
          state <= st_fetch;
        end
        default: begin
          req <= read_req(pc);  // Halted, keep reading pc
        end
      endcase
    end
  end

endmodule

`default_nettype wire

// ==== design/cpu_handler_top.sv ====
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// CPU handler top
// Core, ALU and byte-pin bus sequencer
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`default_nettype none

module cpu_handler_top (
  input  wire                  clk,
  input  wire                  reset,
  input  wire cpu_pkg::byte_t  uio_in,
  output cpu_pkg::byte_t       uo_out,
  output cpu_pkg::byte_t       uio_out,
  output cpu_pkg::byte_t       uio_oe
);

  cpu_pkg::bus_req_t req;
  cpu_pkg::word_t    rdata;
  cpu_pkg::word_t    acc;
  cpu_pkg::word_t    alu_result;
  cpu_pkg::alu_op_t  alu_op;
  logic              alu_zero;
  logic              step;

  cpu_core u_core (
    .clk        (clk),
    .reset      (reset),
    .step       (step),
    .rdata      (rdata),
    .req        (req),
    .alu_op     (alu_op),
    .acc        (acc),
    .alu_result (alu_result),
    .alu_zero   (alu_zero)
  );

  cpu_alu u_alu (
    .a      (acc),
    .b      (rdata),  // Operand word from the last frame
    .op     (alu_op),
    .result (alu_result),
    .zero   (alu_zero)
  );

  bus_frame_sequencer u_seq (
    .clk     (clk),
    .reset   (reset),
    .req     (req),
    .step    (step),
    .rdata   (rdata),
    .uio_in  (uio_in),
    .uo_out  (uo_out),
    .uio_out (uio_out),
    .uio_oe  (uio_oe)
  );

endmodule

`default_nettype wire

// ==== dv/tb_clock_gen.sv ====
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Testbench clock source
// Period 20, reset held 16 cycles
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`default_nettype none

module tb_clock_gen (
  output logic clk,
  output logic reset
);

  initial clk = 1'b0;
  always #10 clk = ~clk;

  initial begin
    reset = 1'b1;
    repeat (16) @(posedge clk);
    #2;
    reset = 1'b0;  // Released just after an edge, like other inputs
  end

endmodule

`default_nettype wire

// ==== dv/bus_memory_model.sv ====
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Bus memory model
// Word memory behind the byte pins, decodes
// each frame and records every write
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`default_nettype none

module bus_memory_model (
  input  wire                 clk,
  input  wire                 reset,
  input  wire cpu_pkg::byte_t uo_out,
  input  wire cpu_pkg::byte_t uio_out,
  input  wire cpu_pkg::byte_t uio_oe,
  output cpu_pkg::byte_t      uio_in
);

  cpu_pkg::word_t    mem [cpu_pkg::word_t];
  cpu_pkg::phase_t   ph;          // Mirrors the sequencer phase
  cpu_pkg::bus_req_t cur;         // Request being gathered from the pins
  cpu_pkg::bus_req_t first_req;
  cpu_pkg::bus_req_t last_write;
  cpu_pkg::byte_t    oe_seen;
  int                frame_count;
  int                write_count;
  int                oe_bad;      // Enable not matching the flag byte
  int                pin_bad;     // Nonzero byte where zeros belong

  // Unwritten words read back a pattern of the whole address
  function automatic cpu_pkg::word_t read_word(input cpu_pkg::word_t addr);
    if (mem.exists(addr)) begin
      return mem[addr];
    end
    return (addr ^ 32'h5a5a_a5a5) + {addr[15:0], addr[31:16]};
  endfunction

  task automatic clear_mem();
    mem.delete();
  endtask

  task automatic load_word(input cpu_pkg::word_t addr, input cpu_pkg::word_t data);
    mem[addr] = data;
  endtask

  always @(posedge clk) begin
    if (reset || ph == cpu_pkg::phase_t'(cpu_pkg::frame_len - 1)) begin
      ph <= '0;
    end else begin
      ph <= ph + 4'd1;
    end
  end

  // Read bytes go out in the cycles the sequencer captures them
  initial uio_in = '0;
  always begin
    @(posedge clk);
    #2;
    if (ph >= 4'd6 && uio_oe == '0) begin
      uio_in = cpu_pkg::byte_t'(read_word(cur.addr) >> (8 * (ph - 4'd6)));
    end else begin
      uio_in = '0;
    end
  end

  // Pins show the content of the previous phase
  always @(negedge clk) begin
    if (reset) begin
      frame_count = 0;
      write_count = 0;
      oe_bad      = 0;
      pin_bad     = 0;
    end else if (ph >= 4'd2 && ph <= 4'd5) begin
      cur.addr[8 * (ph - 4'd2) +: 8]  = uo_out;
      cur.wdata[8 * (ph - 4'd2) +: 8] = uio_out;
      if (ph == 4'd2) begin
        oe_seen = uio_oe;
      end else if (uio_oe != oe_seen) begin
        oe_bad++;
      end
    end else if (ph == 4'd6) begin
      cur.write = uo_out[0];  // Flag byte
      if (uo_out[7:1] != '0 || uio_out != '0) pin_bad++;
      if (uio_oe != {8{cur.write}}) oe_bad++;
      if (frame_count == 0) first_req = cur;
      frame_count++;
      if (cur.write) begin
        mem[cur.addr] = cur.wdata;
        last_write    = cur;
        write_count++;
      end
    end else if (uo_out != '0 || uio_out != '0) begin
      pin_bad++;
    end
  end

endmodule

`default_nettype wire

// ==== dv/cpu_handler_tb.sv ====
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// CPU handler testbench
// Runs small programs from a table and checks
// stored results and pin behavior
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`default_nettype none

module cpu_handler_tb;

  typedef enum {k_arith, k_ldi, k_jz, k_jmp} kind_t;

  typedef struct {
    string            name;
    kind_t            kind;
    cpu_pkg::opcode_t op;
    cpu_pkg::word_t   a;  // First operand or immediate
    cpu_pkg::word_t   b;
  } entry_t;

  logic           clk;
  logic           por;
  logic           run_reset;
  logic           reset;
  cpu_pkg::byte_t uio_in;
  cpu_pkg::byte_t uo_out;
  cpu_pkg::byte_t uio_out;
  cpu_pkg::byte_t uio_oe;
  cpu_pkg::word_t result_addr = 32'h0000_0080;
  entry_t         table_q[$];
  int             value_errors;
  int             other_errors;

  assign reset = por | run_reset;

  tb_clock_gen clock_gen (.clk(clk), .reset(por));

  bus_memory_model mem_model (
    .clk(clk), .reset(reset), .uo_out(uo_out), .uio_out(uio_out),
    .uio_oe(uio_oe), .uio_in(uio_in)
  );

  cpu_handler_top dut (
    .clk(clk), .reset(reset), .uio_in(uio_in), .uo_out(uo_out),
    .uio_out(uio_out), .uio_oe(uio_oe)
  );

  function automatic cpu_pkg::word_t encode(input cpu_pkg::opcode_t op, input cpu_pkg::word_t arg);
    return {op, arg[cpu_pkg::operand_bits-1:0]};
  endfunction

  // Expected store from the instruction rules
  function automatic cpu_pkg::word_t expected_result(input entry_t e);
    case (e.kind)
      k_arith: begin
        case (e.op)
          cpu_pkg::op_add: return e.a + e.b;
          cpu_pkg::op_sub: return e.a - e.b;
          cpu_pkg::op_and: return e.a & e.b;
          default:         return e.a ^ e.b;
        endcase
      end
      k_ldi:   return {4'h0, e.a[27:0]};
      k_jz:    return (e.a[27:0] == '0) ? 32'h222 : 32'h111;
      default: return 32'h222;
    endcase
  endfunction

  task automatic check_word(input string name, input cpu_pkg::word_t exp,
                            input cpu_pkg::word_t act);
    if (exp !== act) begin
      $display("** Error: %s expected %h actual %h", name, exp, act);
      value_errors++;
    end
  endtask

  task automatic check_byte(input string name, input cpu_pkg::byte_t exp,
                            input cpu_pkg::byte_t act);
    if (exp !== act) begin
      $display("** Error: %s expected %h actual %h", name, exp, act);
      value_errors++;
    end
  endtask

  task automatic check_req(input string name, input cpu_pkg::bus_req_t exp,
                           input cpu_pkg::bus_req_t act);
    if (exp !== act) begin
      $display("** Error: %s expected %h actual %h", name, exp, act);
      value_errors++;
    end
  endtask

  task automatic add_entry(input string name, input kind_t kind, input cpu_pkg::opcode_t op,
                           input cpu_pkg::word_t a, input cpu_pkg::word_t b);
    entry_t e;
    e.name = name;
    e.kind = kind;
    e.op   = op;
    e.a    = a;
    e.b    = b;
    table_q.push_back(e);
  endtask

  task automatic load_program(input entry_t e);
    mem_model.clear_mem();
    if (e.kind == k_arith) begin
      mem_model.load_word(32'd0, encode(cpu_pkg::op_load, 32'h40));
      mem_model.load_word(32'd1, encode(e.op, 32'h41));
      mem_model.load_word(32'd2, encode(cpu_pkg::op_store, result_addr));
      mem_model.load_word(32'd3, encode(cpu_pkg::op_halt, 32'd0));
      mem_model.load_word(32'h40, e.a);
      mem_model.load_word(32'h41, e.b);
    end else if (e.kind == k_ldi) begin
      mem_model.load_word(32'd0, encode(cpu_pkg::op_ldi, e.a));
      mem_model.load_word(32'd1, encode(cpu_pkg::op_store, result_addr));
      mem_model.load_word(32'd2, encode(cpu_pkg::op_halt, 32'd0));
    end else begin
      // Taken branch lands on the second store
      mem_model.load_word(32'd0, encode(cpu_pkg::op_ldi, e.a));
      mem_model.load_word(32'd1,
                          encode((e.kind == k_jz) ? cpu_pkg::op_jz : cpu_pkg::op_jmp, 32'd5));
      mem_model.load_word(32'd2, encode(cpu_pkg::op_ldi, 32'h111));
      mem_model.load_word(32'd3, encode(cpu_pkg::op_store, result_addr));
      mem_model.load_word(32'd4, encode(cpu_pkg::op_halt, 32'd0));
      mem_model.load_word(32'd5, encode(cpu_pkg::op_ldi, 32'h222));
      mem_model.load_word(32'd6, encode(cpu_pkg::op_store, result_addr));
      mem_model.load_word(32'd7, encode(cpu_pkg::op_halt, 32'd0));
    end
  endtask

  task automatic check_idle_pins(input string name);
    check_byte({name, " uo_out"}, 8'h00, uo_out);
    check_byte({name, " uio_out"}, 8'h00, uio_out);
    check_byte({name, " uio_oe"}, 8'h00, uio_oe);
  endtask

  task automatic wait_frames(input string name, input int n);
    int start;
    int cycles;
    start = mem_model.frame_count;
    for (cycles = 0; cycles < (n + 2) * cpu_pkg::frame_len; cycles++) begin
      @(posedge clk);
      if (mem_model.frame_count >= start + n) return;
    end
    $display("Timeout: %s saw fewer than %0d frames", name, n);
    other_errors++;
  endtask

  task automatic wait_for_result(input string name, output bit found);
    int cycles;
    found = 1'b0;
    for (cycles = 0; cycles < 400 * cpu_pkg::frame_len && !found; cycles++) begin
      @(posedge clk);
      if (mem_model.write_count > 0) found = 1'b1;
    end
    if (!found) begin
      $display("Timeout: %s never stored a result", name);
      other_errors++;
    end
  endtask

  task automatic run_entry(input entry_t e);
    bit                found;
    int                writes;
    cpu_pkg::bus_req_t fetch0;
    fetch0 = '0;  // Read of address 0
    @(posedge clk);
    #2;
    run_reset = 1'b1;
    load_program(e);
    repeat (3) @(posedge clk);
    @(negedge clk);
    check_idle_pins({e.name, " in reset"});
    @(posedge clk);
    #2;
    run_reset = 1'b0;
    repeat (2) begin
      @(negedge clk);
      check_idle_pins({e.name, " before first address"});
    end
    wait_frames(e.name, 1);
    check_req({e.name, " first request"}, fetch0, mem_model.first_req);
    wait_for_result(e.name, found);
    if (found) begin
      check_word({e.name, " store address"}, result_addr, mem_model.last_write.addr);
      check_word({e.name, " store data"}, expected_result(e), mem_model.last_write.wdata);
      if (mem_model.write_count != 1) begin
        $display("%s: %0d writes seen where one was expected", e.name, mem_model.write_count);
        other_errors++;
      end
      writes = mem_model.write_count;
      wait_frames(e.name, 20);
      if (mem_model.write_count != writes) begin
        $display("%s: memory was written after halt", e.name);
        other_errors++;
      end
    end
    if (mem_model.oe_bad != 0 || mem_model.pin_bad != 0) begin
      $display("%s: uio_oe did not follow the flag byte in %0d frames, %0d pin bytes not zero",
               e.name, mem_model.oe_bad, mem_model.pin_bad);
      other_errors++;
    end
  endtask

  initial begin
    int cycles;
    run_reset    = 1'b0;
    value_errors = 0;
    other_errors = 0;
    void'($urandom(32'hf465));
    add_entry("add random", k_arith, cpu_pkg::op_add, $urandom, $urandom);
    add_entry("add wrap", k_arith, cpu_pkg::op_add, 32'hffff_ffff, 32'h0000_0002);
    add_entry("sub random", k_arith, cpu_pkg::op_sub, $urandom, $urandom);
    add_entry("sub borrow", k_arith, cpu_pkg::op_sub, 32'h0000_0001, 32'h0000_0002);
    add_entry("and random", k_arith, cpu_pkg::op_and, $urandom, $urandom);
    add_entry("xor random", k_arith, cpu_pkg::op_xor, $urandom, $urandom);
    add_entry("ldi random", k_ldi, cpu_pkg::op_ldi, $urandom, 32'd0);
    add_entry("ldi full", k_ldi, cpu_pkg::op_ldi, 32'hffff_ffff, 32'd0);
    add_entry("jz taken", k_jz, cpu_pkg::op_jz, 32'd0, 32'd0);
    add_entry("jz not taken", k_jz, cpu_pkg::op_jz, 32'd5, 32'd0);
    add_entry("jmp", k_jmp, cpu_pkg::op_jmp, 32'd7, 32'd0);
    for (cycles = 0; cycles < 40 && por; cycles++) begin
      @(posedge clk);
    end
    if (por) begin
      $display("Timeout: power-on reset never released");
      other_errors++;
    end
    foreach (table_q[i]) run_entry(table_q[i]);
    $display("Value errors: %0d, other errors: %0d", value_errors, other_errors);
    if (value_errors + other_errors == 0) begin
      $display("Finished with no errors");
    end else begin
      $display("Finished with errors");
    end
    $finish;
  end

endmodule

`default_nettype wire

// ==== all.f ====
design/cpu_pkg.sv
design/cpu_alu.sv
design/bus_frame_sequencer.sv
design/cpu_core.sv
design/cpu_handler_top.sv
dv/tb_clock_gen.sv
dv/bus_memory_model.sv
dv/cpu_handler_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
# Build and run the CPU handler testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing -Wno-fatal -f all.f --top-module cpu_handler_tb -o sim_cpu
./obj_dir/sim_cpu > sim.log 2>&1
cat sim.log

if grep -q "Finished with errors" sim.log; then
  echo "Simulation failed"
  exit 1
fi
grep -q "Finished with no errors" sim.log
echo "Simulation passed"
